/* kbd_config.svh */
`ifndef KBD_CONFIG_SVH
`define KBD_CONFIG_SVH

// flops on each PS/2 line
`define KBD_SYNC_STAGES 3

// scan code that opens a key release
`define KBD_BREAK_PREFIX 8'hF0

// release counter wraps here
`define KBD_COUNT_MOD 100

`endif

/* kbd_pkg.sv */
package kbd_pkg;

    // received byte or set-2 scan code
    typedef logic [7:0] scan_code_t;

    typedef logic [7:0] ascii_t;

    // releases, modulo 100
    typedef logic [6:0] key_count_t;

    typedef enum logic [2:0]
    {
        KEY_IDLE,
        KEY_TAKE,
        KEY_MAKE,
        KEY_BREAK_WAIT,
        KEY_BREAK_TAKE
    } key_state_t;

endpackage

/* seg_pkg.sv */
package seg_pkg;

    typedef logic [3:0] digit_t;

    // active low, bit 0 = a .. bit 6 = g, bit 7 = dp
    typedef logic [7:0] seg_pattern_t;

    localparam seg_pattern_t SEG_BLANK = 8'hFF;

endpackage

/* ps2_keyboard.sv */
`timescale 1ns/1ps
`include "kbd_config.svh"

module ps2_keyboard
#(
    parameter int SYNC_STAGES = `KBD_SYNC_STAGES
)
(
    input  logic               clk,
    input  logic               rst,
    input  logic               ps2_clk,
    input  logic               ps2_data,
    input  logic               nextdata_n,
    output kbd_pkg::scan_code_t data,
    output logic               ready
);

    import kbd_pkg::*;

    localparam logic [5:0] IDLE_MAX = 6'd63;

    logic [SYNC_STAGES-1:0] clk_sync;
    logic [SYNC_STAGES-1:0] dat_sync;
    logic                   clk_s;
    logic                   dat_s;
    logic                   clk_prev;
    logic                   fall;
    logic [3:0]             bit_cnt;
    logic [5:0]             idle_cnt;
    logic [9:0]             frame;
    logic [10:0]            frame_full;
    logic                   frame_ok;
    scan_code_t             hold;

    assign clk_s = clk_sync[SYNC_STAGES-1];
    assign dat_s = dat_sync[SYNC_STAGES-1];
    assign fall  = clk_prev & ~clk_s;

    // frame as it looks once the current bit is in
    assign frame_full = {dat_s, frame};
    assign frame_ok   = ~frame_full[0] & frame_full[10] & (^frame_full[9:1]);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= '1; // lines idle high
            dat_sync <= '1;
            clk_prev <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[SYNC_STAGES-2:0], ps2_clk};
            dat_sync <= {dat_sync[SYNC_STAGES-2:0], ps2_data};
            clk_prev <= clk_s;
        end
    end

    // clock stuck high too long drops a partial frame
    always_ff @(posedge clk)
    begin
        if (!rst)
            idle_cnt <= '0;
        else if (!clk_s)
            idle_cnt <= '0;
        else if (idle_cnt != IDLE_MAX)
            idle_cnt <= idle_cnt + 6'd1;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            bit_cnt <= '0;
        else if (fall)
            bit_cnt <= (bit_cnt == 4'd10) ? 4'd0 : bit_cnt + 4'd1;
        else if (idle_cnt == IDLE_MAX)
            bit_cnt <= '0;
    end

    always_ff @(posedge clk)
    begin
        if (fall)
            frame <= frame_full[10:1]; // lsb first
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            ready <= 1'b0;
        else if (fall && bit_cnt == 4'd10 && frame_ok && !ready)
            ready <= 1'b1;
        else if (!nextdata_n)
            ready <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (fall && bit_cnt == 4'd10 && frame_ok && !ready)
            hold <= frame_full[8:1];
    end

    assign data = hold;

endmodule

/* scan_ascii_rom.sv */
`timescale 1ns/1ps

module scan_ascii_rom
(
    input  logic                clk,
    input  kbd_pkg::scan_code_t addr,
    output kbd_pkg::ascii_t     data
);

    import kbd_pkg::*;

    always_ff @(posedge clk)
    begin
        case (addr)
            8'h45: data <= 8'h30; // 0
            8'h16: data <= 8'h31;
            8'h1E: data <= 8'h32;
            8'h26: data <= 8'h33;
            8'h25: data <= 8'h34;
            8'h2E: data <= 8'h35;
            8'h36: data <= 8'h36;
            8'h3D: data <= 8'h37;
            8'h3E: data <= 8'h38;
            8'h46: data <= 8'h39; // 9
            8'h1C: data <= 8'h41; // A
            8'h32: data <= 8'h42;
            8'h21: data <= 8'h43;
            8'h23: data <= 8'h44;
            8'h24: data <= 8'h45;
            8'h2B: data <= 8'h46;
            8'h34: data <= 8'h47;
            8'h33: data <= 8'h48;
            8'h43: data <= 8'h49;
            8'h3B: data <= 8'h4A;
            8'h42: data <= 8'h4B;
            8'h4B: data <= 8'h4C;
            8'h3A: data <= 8'h4D;
            8'h31: data <= 8'h4E;
            8'h44: data <= 8'h4F;
            8'h4D: data <= 8'h50;
            8'h15: data <= 8'h51;
            8'h2D: data <= 8'h52;
            8'h1B: data <= 8'h53;
            8'h2C: data <= 8'h54;
            8'h3C: data <= 8'h55;
            8'h2A: data <= 8'h56;
            8'h1D: data <= 8'h57;
            8'h22: data <= 8'h58;
            8'h35: data <= 8'h59;
            8'h1A: data <= 8'h5A; // Z
            default: data <= 8'h00; // unmapped
        endcase
    end

endmodule

/* seg7.sv */
`timescale 1ns/1ps

module seg7
(
    input  seg_pkg::digit_t       num,
    input  logic                  blank,
    output seg_pkg::seg_pattern_t seg_out
);

    import seg_pkg::*;

    always_comb
    begin
        if (blank)
            seg_out = SEG_BLANK;
        else
        begin
            case (num)
                4'h0: seg_out = 8'hC0;
                4'h1: seg_out = 8'hF9;
                4'h2: seg_out = 8'hA4;
                4'h3: seg_out = 8'hB0;
                4'h4: seg_out = 8'h99;
                4'h5: seg_out = 8'h92;
                4'h6: seg_out = 8'h82;
                4'h7: seg_out = 8'hF8;
                4'h8: seg_out = 8'h80;
                4'h9: seg_out = 8'h90;
                4'hA: seg_out = 8'h88;
                4'hB: seg_out = 8'h83; // lower-case b
                4'hC: seg_out = 8'hC6;
                4'hD: seg_out = 8'hA1; // lower-case d
                4'hE: seg_out = 8'h86;
                default: seg_out = 8'h8E;
            endcase
        end
    end

endmodule

/* key_display.sv */
`timescale 1ns/1ps
`include "kbd_config.svh"

module key_display
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ps2_clk,
    input  logic                  ps2_dat,
    output seg_pkg::seg_pattern_t seg1,
    output seg_pkg::seg_pattern_t seg2,
    output seg_pkg::seg_pattern_t seg3,
    output seg_pkg::seg_pattern_t seg4,
    output seg_pkg::seg_pattern_t seg5,
    output seg_pkg::seg_pattern_t seg6
);

    import kbd_pkg::*;
    import seg_pkg::*;

    key_state_t state;
    scan_code_t rx_data;
    scan_code_t key_code;
    ascii_t     ascii;
    key_count_t count;
    logic       ready;
    logic       nextdata_n;
    logic       blank;

    digit_t hex_lo;
    digit_t hex_hi;
    digit_t asc_ones;
    digit_t asc_tens;
    digit_t cnt_ones;
    digit_t cnt_tens;

    ps2_keyboard u_rx
    (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_dat),
        .nextdata_n (nextdata_n),
        .data       (rx_data),
        .ready      (ready)
    );

    // release the held byte while taking it
    assign nextdata_n = !(state == KEY_TAKE || state == KEY_BREAK_TAKE);

    always_ff @(posedge clk)
    begin
        if (!rst)
            state <= KEY_IDLE;
        else
        begin
            case (state)
                KEY_IDLE:       if (ready) state <= KEY_TAKE;
                KEY_TAKE:       state <= (rx_data == `KBD_BREAK_PREFIX) ? KEY_BREAK_WAIT
                                                                        : KEY_MAKE;
                KEY_MAKE:       state <= KEY_IDLE;
                KEY_BREAK_WAIT: if (ready) state <= KEY_BREAK_TAKE;
                default:        state <= KEY_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            key_code <= '0;
            blank    <= 1'b1;
            count    <= '0;
        end
        else if (state == KEY_TAKE && rx_data != `KBD_BREAK_PREFIX)
        begin
            key_code <= rx_data;
            blank    <= 1'b0;
        end
        else if (state == KEY_BREAK_TAKE)
        begin
            blank <= 1'b1; // key code byte itself is dropped
            if (count == key_count_t'(`KBD_COUNT_MOD - 1))
                count <= '0;
            else
                count <= count + 7'd1;
        end
    end

    scan_ascii_rom u_rom
    (
        .clk  (clk),
        .addr (key_code),
        .data (ascii)
    );

    assign hex_lo   = key_code[3:0];
    assign hex_hi   = key_code[7:4];
    assign asc_ones = digit_t'(ascii % 8'd10);
    assign asc_tens = digit_t'(ascii / 8'd10); // ascii tops out at 90
    assign cnt_ones = digit_t'(count % 7'd10);
    assign cnt_tens = digit_t'(count / 7'd10);

    seg7 u_seg1 (.num(hex_lo),   .blank(blank), .seg_out(seg1));
    seg7 u_seg2 (.num(hex_hi),   .blank(blank), .seg_out(seg2));
    seg7 u_seg3 (.num(asc_ones), .blank(blank), .seg_out(seg3));
    seg7 u_seg4 (.num(asc_tens), .blank(blank), .seg_out(seg4));

    // count digits always lit
    seg7 u_seg5 (.num(cnt_ones), .blank(1'b0),  .seg_out(seg5));
    seg7 u_seg6 (.num(cnt_tens), .blank(1'b0),  .seg_out(seg6));

endmodule

/* key_display_tb.sv */
`timescale 1ns/1ps
`include "kbd_config.svh"

module key_display_tb;

    import kbd_pkg::*;
    import seg_pkg::*;

    localparam int NUM_TESTS     = 8;
    localparam int SETTLE_MAX    = 200;
    localparam int STABLE_CYCLES = 16;
    localparam int RELEASE_PAIRS = 100;

    logic clk;
    logic rst;
    logic ps2_clk;
    logic ps2_dat;

    seg_pattern_t seg1;
    seg_pattern_t seg2;
    seg_pattern_t seg3;
    seg_pattern_t seg4;
    seg_pattern_t seg5;
    seg_pattern_t seg6;
    seg_pattern_t shown [6];

    logic [31:0] lfsr_state;

    string      t_name   [NUM_TESTS];
    int         t_nbytes [NUM_TESTS];
    scan_code_t t_byte   [NUM_TESTS][2];
    logic       t_par_ok [NUM_TESTS][2];
    scan_code_t t_hex    [NUM_TESTS];
    ascii_t     t_ascii  [NUM_TESTS];
    int         t_count  [NUM_TESTS];
    logic       t_blank  [NUM_TESTS];

    key_display DUT
    (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .seg1    (seg1),
        .seg2    (seg2),
        .seg3    (seg3),
        .seg4    (seg4),
        .seg5    (seg5),
        .seg6    (seg6)
    );

    assign shown[0] = seg1;
    assign shown[1] = seg2;
    assign shown[2] = seg3;
    assign shown[3] = seg4;
    assign shown[4] = seg5;
    assign shown[5] = seg6;

    always #50 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            val = (val << 1) | {31'd0, lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // expected pattern, segments gfedcba active high before inversion
    function automatic seg_pattern_t seg_ref(input int d, input logic off);
        logic [6:0] on;
        case (d)
            0:  on = 7'b0111111;
            1:  on = 7'b0000110;
            2:  on = 7'b1011011;
            3:  on = 7'b1001111;
            4:  on = 7'b1100110;
            5:  on = 7'b1101101;
            6:  on = 7'b1111101;
            7:  on = 7'b0000111;
            8:  on = 7'b1111111;
            9:  on = 7'b1101111;
            10: on = 7'b1110111;
            11: on = 7'b1111100; // b
            12: on = 7'b0111001;
            13: on = 7'b1011110; // d
            14: on = 7'b1111001;
            default: on = 7'b1110001;
        endcase
        seg_ref = off ? SEG_BLANK : {1'b1, ~on}; // dp stays dark
    endfunction

    task automatic tick(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_seg(input string name, input int pos, input seg_pattern_t exp,
                               input seg_pattern_t act);
        if (act !== exp)
        begin
            $display("mismatch %s seg%0d: expected %h, actual %h", name, pos, exp, act);
            abort_run();
        end
    endtask

    // start, 8 data bits lsb first, odd parity, stop
    task automatic send_frame(input scan_code_t b, input logic par_ok);
        logic        par;
        logic [10:0] bits;
        par  = ~(^b);
        if (!par_ok)
            par = ~par;
        bits = {1'b1, par, b, 1'b0};
        for (int i = 0; i < 11; i++)
        begin
            ps2_dat = bits[i];
            tick(4);
            ps2_clk = 1'b0; // receiver samples on this edge
            tick(4);
            ps2_clk = 1'b1;
        end
        tick(4);
    endtask

    task automatic send_gap();
        int gap;
        rand_bits(4, gap);
        tick(gap);
    endtask

    // display must hold the expected value for a while before it counts
    task automatic check_display(input string name, input scan_code_t hex, input ascii_t asc,
                                 input int cnt, input logic off);
        seg_pattern_t exp_seg [6];
        int           stable;
        int           waited;
        logic         all_ok;
        exp_seg[0] = seg_ref(int'(hex[3:0]), off);
        exp_seg[1] = seg_ref(int'(hex[7:4]), off);
        exp_seg[2] = seg_ref(int'(asc) % 10, off);
        exp_seg[3] = seg_ref(int'(asc) / 10, off);
        exp_seg[4] = seg_ref(cnt % 10, 1'b0);
        exp_seg[5] = seg_ref(cnt / 10, 1'b0);
        stable = 0;
        waited = 0;
        while (stable < STABLE_CYCLES && waited < SETTLE_MAX)
        begin
            tick(1);
            waited++;
            all_ok = 1'b1;
            for (int j = 0; j < 6; j++)
                if (shown[j] !== exp_seg[j])
                    all_ok = 1'b0;
            stable = all_ok ? stable + 1 : 0;
        end
        if (stable < STABLE_CYCLES)
        begin
            for (int j = 0; j < 6; j++)
                compare_seg(name, j + 1, exp_seg[j], shown[j]);
            $display("display did not settle in test %s", name);
            abort_run();
        end
    endtask

    task automatic set_entry(input int i, input string name, input int nb,
                             input scan_code_t b0, input logic p0,
                             input scan_code_t b1, input logic p1,
                             input scan_code_t hex, input ascii_t asc,
                             input int cnt, input logic off);
        t_name[i]      = name;
        t_nbytes[i]    = nb;
        t_byte[i][0]   = b0;
        t_par_ok[i][0] = p0;
        t_byte[i][1]   = b1;
        t_par_ok[i][1] = p1;
        t_hex[i]       = hex;
        t_ascii[i]     = asc;
        t_count[i]     = cnt;
        t_blank[i]     = off;
    endtask

    // ascii column is decimal: A = 65, 7 = 55, Z = 90
    task automatic load_table();
        set_entry(0, "after reset",    0, 8'h00, 1'b1, 8'h00, 1'b1, 8'h00, 8'd0,  0, 1'b1);
        set_entry(1, "make A",         1, 8'h1C, 1'b1, 8'h00, 1'b1, 8'h1C, 8'd65, 0, 1'b0);
        set_entry(2, "break A",        2, 8'hF0, 1'b1, 8'h1C, 1'b1, 8'h00, 8'd0,  1, 1'b1);
        set_entry(3, "make 7",         1, 8'h3D, 1'b1, 8'h00, 1'b1, 8'h3D, 8'd55, 1, 1'b0);
        set_entry(4, "unmapped esc",   1, 8'h76, 1'b1, 8'h00, 1'b1, 8'h76, 8'd0,  1, 1'b0);
        set_entry(5, "bad parity",     1, 8'h1C, 1'b0, 8'h00, 1'b1, 8'h76, 8'd0,  1, 1'b0);
        set_entry(6, "good after bad", 1, 8'h1A, 1'b1, 8'h00, 1'b1, 8'h1A, 8'd90, 1, 1'b0);
        set_entry(7, "break Z",        2, 8'hF0, 1'b1, 8'h1A, 1'b1, 8'h00, 8'd0,  2, 1'b1);
    endtask

    initial
    begin
        int         exp_cnt;
        int         draw;
        scan_code_t code;
        clk        = 1'b0;
        rst        = 1'b0;
        ps2_clk    = 1'b1; // both lines idle high
        ps2_dat    = 1'b1;
        lfsr_state = 32'h1d89;
        load_table();
        tick(10);
        rst = 1'b1;

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            for (int k = 0; k < t_nbytes[t]; k++)
            begin
                send_gap();
                send_frame(t_byte[t][k], t_par_ok[t][k]);
            end
            check_display(t_name[t], t_hex[t], t_ascii[t], t_count[t], t_blank[t]);
        end

        // press and release random codes, count passes 99 -> 0 on the way
        exp_cnt = t_count[NUM_TESTS-1];
        for (int p = 0; p < RELEASE_PAIRS; p++)
        begin
            rand_bits(8, draw);
            code = scan_code_t'(draw);
            if (code == `KBD_BREAK_PREFIX)
                code = 8'h0F;
            send_gap();
            send_frame(code, 1'b1);
            send_gap();
            send_frame(`KBD_BREAK_PREFIX, 1'b1);
            send_gap();
            send_frame(code, 1'b1);
            exp_cnt = (exp_cnt + 1) % `KBD_COUNT_MOD;
            check_display($sformatf("release pair %0d", p), code, 8'd0, exp_cnt, 1'b1);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

/* key_display.f */
+incdir+.
kbd_pkg.sv
seg_pkg.sv
ps2_keyboard.sv
scan_ascii_rom.sv
seg7.sv
key_display.sv
key_display_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the key display testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f key_display.f --top-module key_display_tb \
    -o key_display_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/key_display_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
fi

if grep -qx "All checks passed" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
